//--- source/core_pkg.sv
//--------------------
// widths, register counts, opcode and function codes, typedefs
// and the decode and execute stage packets
//--------------------
package core_pkg;

	//--------------------
	// widths and counts
	//--------------------
	localparam int XLEN     = 64;	// datapath width
	localparam int AREG_NUM = 32;	// architectural regs
	localparam int PREG_NUM = 64;	// physical regs
	localparam int AREG_W   = $clog2(AREG_NUM);
	localparam int PREG_W   = $clog2(PREG_NUM);
	localparam int FL_NUM   = PREG_NUM - AREG_NUM;	// spare pregs held by free list
	localparam int FL_PTR_W = $clog2(FL_NUM);
	localparam int LIT_W    = 8;	// operate-format literal

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [31:0]       inst_t;
	typedef logic [AREG_W-1:0] areg_t;
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [5:0]        opcode_t;
	typedef logic [6:0]        func_t;
	typedef logic [LIT_W-1:0]  lit_t;
	typedef logic [2:0]        alu_op_t;

	localparam areg_t ZERO_REG = 5'd31;	// r31 reads zero, writes dropped

	//--------------------
	// operate format codes
	//--------------------
	localparam opcode_t OP_INTA = 6'h10;	// integer arithmetic group
	localparam opcode_t OP_INTL = 6'h11;	// integer logical group

	localparam func_t FN_ADDQ = 7'h20;	// inta
	localparam func_t FN_SUBQ = 7'h29;	// inta
	localparam func_t FN_AND  = 7'h00;	// intl
	localparam func_t FN_BIS  = 7'h20;	// intl, same value as addq
	localparam func_t FN_XOR  = 7'h40;	// intl

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;

	// decode to execute
	typedef struct packed {
		logic    valid;
		logic    illegal;	// flagged, no state change
		alu_op_t alu_op;
		preg_t   opa_preg;
		logic    opa_zero;	// ra is r31
		preg_t   opb_preg;
		logic    opb_zero;	// rb is r31
		logic    use_lit;	// opb from literal
		lit_t    lit;
		areg_t   dest_areg;
		preg_t   dest_preg;	// newly allocated
		preg_t   old_preg;	// previous mapping of rc
		logic    wr_en;	// clear for r31 or illegal
	} dec_pkt_t;

	// execute to result
	typedef struct packed {
		logic  valid;
		logic  illegal;
		areg_t dest_areg;
		word_t value;
		preg_t old_preg;
		logic  wr_en;
	} exe_pkt_t;

endpackage

//--- source/decode_rename.sv
//--------------------
// instruction decode, map table lookup and rename, decode packet
//--------------------
module decode_rename (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               inst_vld_i,
	input  core_pkg::inst_t    inst_i,
	input  core_pkg::preg_t    free_preg_i,	// head of free list
	output logic               alloc_o,	// pop free list
	output core_pkg::dec_pkt_t dec_pkt_o
);
	import core_pkg::*;

	opcode_t  opcode;
	func_t    func;
	areg_t    ra;
	areg_t    rb;
	areg_t    rc;
	lit_t     lit;
	logic     use_lit;
	logic     illegal;
	logic     wr_en;
	alu_op_t  alu_op;
	preg_t    map_q [AREG_NUM];	// areg -> preg
	dec_pkt_t dec_pkt_d;

	//--------------------
	// field split
	//--------------------
	assign opcode  = inst_i[31:26];
	assign ra      = inst_i[25:21];
	assign rb      = inst_i[20:16];
	assign lit     = inst_i[20:13];	// overlaps rb
	assign use_lit = inst_i[12];
	assign func    = inst_i[11:5];
	assign rc      = inst_i[4:0];

	always_comb begin
		illegal = 1'b0;
		alu_op  = ALU_ADD;	// don't care when illegal
		case (opcode)
			OP_INTA: begin
				case (func)
					FN_ADDQ: alu_op = ALU_ADD;
					FN_SUBQ: alu_op = ALU_SUB;
					default: illegal = 1'b1;
				endcase
			end
			OP_INTL: begin
				case (func)
					FN_AND:  alu_op = ALU_AND;
					FN_BIS:  alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;	// unknown opcode
		endcase
	end

	assign wr_en   = ~illegal & (rc != ZERO_REG);
	assign alloc_o = inst_vld_i & wr_en;	// only real writes rename

	//--------------------
	// map table
	//--------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				map_q[i] <= preg_t'(i);	// identity
			end
		end else if (alloc_o) begin
			map_q[rc] <= free_preg_i;	// seen by next strobe
		end
	end

	always_comb begin
		dec_pkt_d.valid     = inst_vld_i;
		dec_pkt_d.illegal   = illegal;
		dec_pkt_d.alu_op    = alu_op;
		dec_pkt_d.opa_preg  = map_q[ra];
		dec_pkt_d.opa_zero  = (ra == ZERO_REG);
		dec_pkt_d.opb_preg  = map_q[rb];
		dec_pkt_d.opb_zero  = (rb == ZERO_REG);
		dec_pkt_d.use_lit   = use_lit;
		dec_pkt_d.lit       = lit;
		dec_pkt_d.dest_areg = rc;
		dec_pkt_d.dest_preg = free_preg_i;	// only meaningful with wr_en
		dec_pkt_d.old_preg  = map_q[rc];	// freed at retire
		dec_pkt_d.wr_en     = wr_en;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_pkt_o <= '0;
		end else begin
			dec_pkt_o <= dec_pkt_d;	// E0
		end
	end

endmodule

//--- source/free_list.sv
//--------------------
// circular queue of free physical registers
//--------------------
module free_list (
	input  logic            clk,
	input  logic            rst_n_i,
	input  logic            alloc_i,	// advance head
	input  logic            free_i,	// push at tail
	input  core_pkg::preg_t free_preg_i,
	output core_pkg::preg_t head_preg_o
);
	import core_pkg::*;

	preg_t               fifo_q [FL_NUM];
	logic [FL_PTR_W-1:0] head_q;
	logic [FL_PTR_W-1:0] tail_q;

	//--------------------
	// pointers
	//--------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head_q <= '0;
			tail_q <= '0;	// full, so tail meets head
		end else begin
			if (alloc_i) begin
				head_q <= head_q + 1'b1;	// wraps at FL_NUM
			end
			if (free_i) begin
				tail_q <= tail_q + 1'b1;
			end
		end
	end

	// entries start as the pregs above the identity map
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < FL_NUM; i++) begin
				fifo_q[i] <= preg_t'(AREG_NUM + i);
			end
		end else if (free_i) begin
			fifo_q[tail_q] <= free_preg_i;	// old preg back in
		end
	end

	assign head_preg_o = fifo_q[head_q];	// next preg to hand out

endmodule

//--- source/execute.sv
//--------------------
// physical register file, operand read, ALU and execute packet
//--------------------
module execute (
	input  logic               clk,
	input  logic               rst_n_i,
	input  core_pkg::dec_pkt_t dec_pkt_i,
	output core_pkg::exe_pkt_t exe_pkt_o
);
	import core_pkg::*;

	word_t    rf_q [PREG_NUM];
	word_t    opa;
	word_t    opb;
	word_t    alu_res;
	logic     rf_we;
	exe_pkt_t exe_pkt_d;

	//--------------------
	// operand read
	//--------------------
	assign opa = dec_pkt_i.opa_zero ? '0 : rf_q[dec_pkt_i.opa_preg];

	always_comb begin
		if (dec_pkt_i.use_lit) begin
			opb = word_t'(dec_pkt_i.lit);	// zero extended
		end else if (dec_pkt_i.opb_zero) begin
			opb = '0;
		end else begin
			opb = rf_q[dec_pkt_i.opb_preg];
		end
	end

	always_comb begin
		case (dec_pkt_i.alu_op)
			ALU_ADD: alu_res = opa + opb;	// wraps at 64 bits
			ALU_SUB: alu_res = opa - opb;
			ALU_AND: alu_res = opa & opb;
			ALU_OR:  alu_res = opa | opb;
			ALU_XOR: alu_res = opa ^ opb;
			default: alu_res = '0;
		endcase
	end

	assign rf_we = dec_pkt_i.valid & dec_pkt_i.wr_en;

	//--------------------
	// register file write, E1
	//--------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < PREG_NUM; i++) begin
				rf_q[i] <= '0;
			end
		end else if (rf_we) begin
			rf_q[dec_pkt_i.dest_preg] <= alu_res;	// next read sees it
		end
	end

	always_comb begin
		exe_pkt_d.valid     = dec_pkt_i.valid;
		exe_pkt_d.illegal   = dec_pkt_i.illegal;
		exe_pkt_d.dest_areg = dec_pkt_i.dest_areg;
		exe_pkt_d.value     = alu_res;
		exe_pkt_d.old_preg  = dec_pkt_i.old_preg;
		exe_pkt_d.wr_en     = dec_pkt_i.wr_en;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exe_pkt_o <= '0;
		end else begin
			exe_pkt_o <= exe_pkt_d;
		end
	end

endmodule

//--- source/result.sv
//--------------------
// retire register and old preg return
//--------------------
module result (
	input  logic               clk,
	input  logic               rst_n_i,
	input  core_pkg::exe_pkt_t exe_pkt_i,
	output logic               free_o,	// to free list
	output core_pkg::preg_t    free_preg_o,
	output logic               retire_vld_o,
	output logic               retire_illegal_o,
	output core_pkg::areg_t    retire_areg_o,
	output core_pkg::word_t    retire_value_o
);
	import core_pkg::*;

	logic  vld_q;	// stands in for the rob head
	logic  illegal_q;
	areg_t areg_q;
	word_t value_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= exe_pkt_i.valid;	// E2, one cycle each
		end
	end

	always_ff @(posedge clk) begin
		illegal_q <= exe_pkt_i.illegal;
		areg_q    <= exe_pkt_i.dest_areg;
		value_q   <= exe_pkt_i.value;
	end

	// old mapping goes back at the retire edge
	assign free_o      = exe_pkt_i.valid & exe_pkt_i.wr_en;
	assign free_preg_o = exe_pkt_i.old_preg;

	assign retire_vld_o     = vld_q;
	assign retire_illegal_o = illegal_q;
	assign retire_areg_o    = areg_q;
	assign retire_value_o   = value_q;

endmodule

//--- source/core.sv
//--------------------
// core top, decode/rename, free list, execute and result
//--------------------
module core (
	input  logic            clk,
	input  logic            rst_n_i,
	input  logic            inst_vld_i,	// single cycle strobe
	input  core_pkg::inst_t inst_i,
	output logic            retire_vld_o,
	output logic            retire_illegal_o,
	output core_pkg::areg_t retire_areg_o,
	output core_pkg::word_t retire_value_o
);
	import core_pkg::*;

	//--------------------
	// stage wires
	//--------------------
	dec_pkt_t dec_pkt;	// decode -> execute
	exe_pkt_t exe_pkt;	// execute -> result
	logic     alloc;
	preg_t    head_preg;
	logic     free;
	preg_t    free_preg;

	decode_rename decode0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.inst_vld_i  (inst_vld_i),
		.inst_i      (inst_i),
		.free_preg_i (head_preg),	// [free list]
		.alloc_o     (alloc),
		.dec_pkt_o   (dec_pkt)
	);

	free_list free_list0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.alloc_i     (alloc),	// [decode]
		.free_i      (free),	// [result]
		.free_preg_i (free_preg),
		.head_preg_o (head_preg)
	);

	execute execute0 (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.dec_pkt_i (dec_pkt),
		.exe_pkt_o (exe_pkt)
	);

	result result0 (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.exe_pkt_i        (exe_pkt),
		.free_o           (free),
		.free_preg_o      (free_preg),
		.retire_vld_o     (retire_vld_o),
		.retire_illegal_o (retire_illegal_o),
		.retire_areg_o    (retire_areg_o),
		.retire_value_o   (retire_value_o)
	);

endmodule

//--- testbench/core_asserts.sv
//--------------------
// architectural reference model and retire checks, bound into core
//--------------------
module core_asserts (
	input logic            clk,
	input logic            rst_n_i,
	input logic            inst_vld_i,
	input core_pkg::inst_t inst_i,
	input logic            retire_vld_i,
	input logic            retire_illegal_i,
	input core_pkg::areg_t retire_areg_i,
	input core_pkg::word_t retire_value_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	typedef struct packed {
		logic  vld;
		logic  illegal;
		areg_t areg;
		word_t value;
	} ret_t;

	word_t arch_q [AREG_NUM];	// model regs, r31 never written
	ret_t  exp_q [3];	// expected retirements, [2] is due next
	ret_t  exp_new;
	ret_t  exp_head;
	word_t opa_m;
	word_t opb_m;
	int    err_cnt = 0;

	//--------------------
	// model
	//--------------------
	assign opa_m = (inst_i[25:21] == ZERO_REG) ? '0 : arch_q[inst_i[25:21]];
	assign opb_m = inst_i[12] ? word_t'(inst_i[20:13]) :	// literal, zero extended
		(inst_i[20:16] == ZERO_REG) ? '0 : arch_q[inst_i[20:16]];

	always_comb begin
		exp_new.vld     = inst_vld_i;
		exp_new.illegal = 1'b0;
		exp_new.areg    = inst_i[4:0];	// rc
		exp_new.value   = '0;
		case ({inst_i[31:26], inst_i[11:5]})
			{OP_INTA, FN_ADDQ}: exp_new.value = opa_m + opb_m;
			{OP_INTA, FN_SUBQ}: exp_new.value = opa_m - opb_m;
			{OP_INTL, FN_AND}:  exp_new.value = opa_m & opb_m;
			{OP_INTL, FN_BIS}:  exp_new.value = opa_m | opb_m;
			{OP_INTL, FN_XOR}:  exp_new.value = opa_m ^ opb_m;
			default:            exp_new.illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				arch_q[i] <= '0;
			end
			for (int i = 0; i < 3; i++) begin
				exp_q[i] <= '0;
			end
		end else begin
			exp_q[0] <= exp_new;	// strobe seen at E0
			exp_q[1] <= exp_q[0];
			exp_q[2] <= exp_q[1];	// lines up with retire after E2
			if (exp_new.vld && !exp_new.illegal && exp_new.areg != ZERO_REG) begin
				arch_q[exp_new.areg] <= exp_new.value;
			end
		end
	end

	assign exp_head = exp_q[2];

	//--------------------
	// retire checks
	//--------------------
	vld_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_vld_i == exp_head.vld)
	else begin
		err_cnt++;
		$error("MISMATCH retire_vld_o got %h expected %h",
			$sampled(retire_vld_i), $sampled(exp_head.vld));
	end

	illegal_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_vld_i |-> retire_illegal_i == exp_head.illegal)
	else begin
		err_cnt++;
		$error("MISMATCH retire_illegal_o got %h expected %h",
			$sampled(retire_illegal_i), $sampled(exp_head.illegal));
	end

	areg_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_vld_i |-> retire_areg_i == exp_head.areg)
	else begin
		err_cnt++;
		$error("MISMATCH retire_areg_o got %h expected %h",
			$sampled(retire_areg_i), $sampled(exp_head.areg));
	end

	// value only means something for a legal op
	value_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_vld_i && !exp_head.illegal |-> retire_value_i == exp_head.value)
	else begin
		err_cnt++;
		$error("MISMATCH retire_value_o got %h expected %h",
			$sampled(retire_value_i), $sampled(exp_head.value));
	end

endmodule

bind core core_asserts asserts0 (
	.clk              (clk),
	.rst_n_i          (rst_n_i),
	.inst_vld_i       (inst_vld_i),
	.inst_i           (inst_i),
	.retire_vld_i     (retire_vld_o),
	.retire_illegal_i (retire_illegal_o),
	.retire_areg_i    (retire_areg_o),
	.retire_value_i   (retire_value_o)
);

//--- testbench/core_tb.sv
//--------------------
// core testbench, clock, reset, directed and LCG stimulus
//--------------------
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam int RAND_NUM  = 600;	// random instructions
	localparam int DRAIN_MAX = 20;	// edges for the pipe to empty
	localparam int RUN_MAX   = 1000000;	// ns, whole run

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        inst_vld_i;
	inst_t       inst_i;
	logic        retire_vld_o;
	logic        retire_illegal_o;
	areg_t       retire_areg_o;
	word_t       retire_value_o;
	logic [31:0] lcg_state = 32'h4e68_a71f;
	logic [31:0] gap_r;
	int          issued_cnt = 0;
	int          retired_cnt = 0;
	int          timeout_cnt = 0;
	int          wait_cnt;

	core dut0 (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.inst_vld_i       (inst_vld_i),
		.inst_i           (inst_i),
		.retire_vld_o     (retire_vld_o),
		.retire_illegal_o (retire_illegal_o),
		.retire_areg_o    (retire_areg_o),
		.retire_value_o   (retire_value_o)
	);

	always #5 clk = ~clk;	// 10 ns period

	always @(negedge clk) begin
		if (retire_vld_o) begin
			retired_cnt++;	// sampled away from the edge
		end
	end

	//--------------------
	// stimulus helpers
	//--------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic inst_t enc_reg(input opcode_t op, input func_t fn,
		input areg_t ra, input areg_t rb, input areg_t rc);
		return {op, ra, rb, 3'b000, 1'b0, fn, rc};
	endfunction

	function automatic inst_t enc_lit(input opcode_t op, input func_t fn,
		input areg_t ra, input lit_t lit, input areg_t rc);
		return {op, ra, lit, 1'b1, fn, rc};
	endfunction

	// small register set so that dependencies are frequent
	function automatic areg_t pick_reg(input logic [3:0] bits);
		return (bits == 4'hf) ? ZERO_REG : areg_t'(bits[2:0]);
	endfunction

	function automatic inst_t rand_inst();
		opcode_t     op_tab [8] = '{OP_INTA, OP_INTA, OP_INTL, OP_INTL,
			OP_INTL, OP_INTA, OP_INTA, OP_INTL};
		func_t       fn_tab [8] = '{FN_ADDQ, FN_SUBQ, FN_AND, FN_BIS,
			FN_XOR, FN_ADDQ, FN_SUBQ, FN_BIS};
		logic [31:0] x;
		logic [31:0] y;
		opcode_t     op;
		func_t       fn;
		x  = lcg_next();
		y  = lcg_next();
		op = op_tab[x[31:29]];
		fn = fn_tab[x[31:29]];
		if (x[28:26] == 3'b111) begin
			op = y[22] ? 6'h3f : OP_INTA;	// unknown opcode or function
			fn = 7'h7f;
		end
		return y[31] ? enc_lit(op, fn, pick_reg(x[25:22]), y[30:23], pick_reg(x[17:14])) :
			enc_reg(op, fn, pick_reg(x[25:22]), pick_reg(x[21:18]), pick_reg(x[17:14]));
	endfunction

	task automatic drive_cycle(input logic vld, input inst_t inst);
		@(posedge clk);
		#1;	// off the edge
		inst_vld_i = vld;
		inst_i     = inst;
		if (vld) begin
			issued_cnt++;
		end
	endtask

	task automatic issue(input inst_t inst);
		drive_cycle(1'b1, inst);
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, '0);
	endtask

	//--------------------
	// test sequence
	//--------------------
	initial begin
		rst_n_i    = 1'b0;
		inst_vld_i = 1'b0;
		inst_i     = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		for (int i = 1; i <= 6; i++) begin
			issue(enc_lit(OP_INTL, FN_BIS, ZERO_REG, lit_t'(37 * i + 11), areg_t'(i)));
		end
		issue(enc_reg(OP_INTA, FN_ADDQ, 5'd1, 5'd2, 5'd7));
		issue(enc_reg(OP_INTA, FN_SUBQ, 5'd1, 5'd6, 5'd8));	// goes below zero
		issue(enc_reg(OP_INTL, FN_AND, 5'd7, 5'd8, 5'd9));
		issue(enc_reg(OP_INTL, FN_BIS, 5'd3, 5'd4, 5'd10));
		issue(enc_reg(OP_INTL, FN_XOR, 5'd9, 5'd10, 5'd11));
		issue(enc_lit(OP_INTA, FN_ADDQ, 5'd1, 8'hff, 5'd12));
		idle(4);
		for (int i = 0; i < 40; i++) begin
			issue(enc_reg(OP_INTA, FN_ADDQ, 5'd8, 5'd8, 5'd8));	// doubling chain
		end
		issue(enc_reg(OP_INTA, FN_ADDQ, 5'd1, 5'd2, ZERO_REG));	// retires, writes nothing
		issue(enc_reg(OP_INTL, FN_BIS, ZERO_REG, ZERO_REG, 5'd13));
		issue(enc_lit(OP_INTA, FN_SUBQ, ZERO_REG, 8'h01, 5'd14));	// all ones
		issue(enc_reg(6'h3f, FN_ADDQ, 5'd1, 5'd2, 5'd1));	// unknown opcode
		issue(enc_reg(OP_INTL, 7'h7f, 5'd1, 5'd2, 5'd2));	// unknown function
		issue(enc_reg(OP_INTA, FN_ADDQ, 5'd1, 5'd2, 5'd15));	// r1, r2 untouched
		idle(5);
		for (int n = 0; n < RAND_NUM; n++) begin
			issue(rand_inst());
			gap_r = lcg_next();
			if (gap_r[31:30] == 2'b00) begin
				idle(int'(gap_r[29:28]) + 1);
			end
		end
		idle(1);
		wait_cnt = 0;
		while (retired_cnt != issued_cnt && wait_cnt < DRAIN_MAX) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (retired_cnt != issued_cnt) begin
			timeout_cnt++;
			$display("timeout: only %0d of %0d instructions retired", retired_cnt, issued_cnt);
		end
		idle(3);	// nothing in flight here
		$display("assertion errors: %0d, timeouts: %0d", dut0.asserts0.err_cnt, timeout_cnt);
		if (dut0.asserts0.err_cnt == 0 && timeout_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(RUN_MAX);
		$display("timeout: simulation did not finish within %0d ns", RUN_MAX);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- list.f
source/core_pkg.sv
source/decode_rename.sv
source/free_list.sv
source/execute.sv
source/result.sv
source/core.sv
testbench/core_asserts.sv
testbench/core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := core_tb
FLIST      := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
